// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int REG_W     = 3;
    localparam int MEM_DEPTH = 1 << ADDR_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [REG_W-1:0]  reg_addr_t;

    typedef enum logic [2:0] {
        OPC_LDR  = 3'b011,
        OPC_STR  = 3'b100,
        OPC_ALU  = 3'b101,
        OPC_MOV  = 3'b110,
        OPC_HALT = 3'b111
    } opcode_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_CMP, ALU_AND, ALU_MVN} alu_op_e;
    typedef enum logic [1:0] {SH_NONE, SH_LSL, SH_LSR, SH_ASR} shift_e;
    typedef enum logic [1:0] {SEL_RM, SEL_RD, SEL_RN} reg_sel_e;
    typedef enum logic [1:0] {WB_C, WB_IMM8, WB_MEM} wb_sel_e;

    typedef struct packed {
        opcode_e   opcode;
        alu_op_e   op;
        reg_addr_t rn;
        reg_addr_t rd;
        reg_addr_t rm;
        shift_e    shift;
        word_t     imm5;   // sign extended
        word_t     imm8;   // sign extended
    } instr_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } flags_t;

    typedef struct packed {
        reg_sel_e reg_sel;
        wb_sel_e  wb_sel;
        logic     reg_wr;
        logic     load_a;
        logic     load_b;
        logic     load_c;
        logic     load_status;
        logic     zero_a;
        logic     use_imm5;
        logic     no_shift;
    } ctrl_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               wr_en,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data,
    input  cpu_pkg::reg_addr_t rd_addr,
    output cpu_pkg::word_t     rd_data
);
    import cpu_pkg::*;

    word_t regs [1 << REG_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read is combinational, new value seen after the write edge
    assign rd_data = regs[rd_addr];

endmodule

// ==== hw/alu_shift.sv ====
`timescale 1ns/1ps

module alu_shift (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::shift_e  shift,
    input  logic             no_shift,
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t   result,
    output cpu_pkg::flags_t  alu_flags
);
    import cpu_pkg::*;

    word_t b_sh;
    word_t diff;

    always_comb begin
        b_sh = b;
        if (!no_shift) begin
            case (shift)
                SH_LSL:  b_sh = {b[WORD_W-2:0], 1'b0};
                SH_LSR:  b_sh = {1'b0, b[WORD_W-1:1]};
                SH_ASR:  b_sh = {b[WORD_W-1], b[WORD_W-1:1]};
                default: b_sh = b;
            endcase
        end
    end

    assign diff = a - b_sh;

    always_comb begin
        alu_flags = '0; // only CMP sets flags
        case (op)
            ALU_ADD: result = a + b_sh;
            ALU_CMP: begin
                result      = diff;
                alu_flags.z = (diff == '0);
                alu_flags.n = diff[WORD_W-1];
                alu_flags.v = (a[WORD_W-1] != b_sh[WORD_W-1]) &&
                              (diff[WORD_W-1] != a[WORD_W-1]);
            end
            ALU_AND: result = a & b_sh;
            default: result = ~b_sh; // MVN
        endcase
    end

endmodule

// ==== hw/cpu_ctrl.sv ====
`timescale 1ns/1ps

module cpu_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  cpu_pkg::instr_t instr,
    output cpu_pkg::ctrl_t  ctrl,
    output logic            load_pc,
    output logic            pc_from_start,
    output logic            load_ir,
    output logic            load_addr,
    output logic            addr_from_pc,
    output logic            mem_we,
    output logic            busy,
    output logic            halted
);
    import cpu_pkg::*;

    typedef enum logic [4:0] {
        IDLE, PC_FIRST, PC_NEXT, PC_READ, IR_LOAD, DECODE,
        RD_A, RD_B, EXEC, WRITE_BACK,
        ADDR_LOAD, ADDR_SEL, MEM_READ, MEM_SELECT,
        STR_RD_B, STR_EXEC, MEM_WRITE, WRITE_WAIT
    } state_e;

    state_e state;
    state_e state_next;
    logic   is_mov_imm;
    logic   b_only;
    logic   is_mem;
    logic   is_cmp;

    assign is_mov_imm = (instr.opcode == OPC_MOV) && instr.op[1]; // op 1x is the imm form
    assign b_only     = ((instr.opcode == OPC_MOV) && !instr.op[1]) ||
                        ((instr.opcode == OPC_ALU) && (instr.op == ALU_MVN));
    assign is_mem     = (instr.opcode == OPC_LDR) || (instr.opcode == OPC_STR);
    assign is_cmp     = (instr.opcode == OPC_ALU) && (instr.op == ALU_CMP);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (start) state_next = PC_FIRST;
            PC_FIRST:   state_next = PC_READ;
            PC_NEXT:    state_next = PC_READ;
            PC_READ:    state_next = IR_LOAD;
            IR_LOAD:    state_next = DECODE;
            DECODE: begin
                case (instr.opcode)
                    OPC_HALT: state_next = IDLE;
                    OPC_MOV:  state_next = is_mov_imm ? WRITE_BACK : RD_B;
                    OPC_ALU:  state_next = b_only ? RD_B : RD_A;
                    OPC_LDR:  state_next = RD_A;
                    OPC_STR:  state_next = RD_A;
                    default:  state_next = PC_NEXT; // unknown opcode skipped
                endcase
            end
            RD_A:       state_next = is_mem ? EXEC : RD_B;
            RD_B:       state_next = EXEC;
            EXEC: begin
                if (is_cmp) state_next = PC_NEXT;
                else if (is_mem) state_next = ADDR_LOAD;
                else state_next = WRITE_BACK;
            end
            WRITE_BACK: state_next = PC_NEXT;
            ADDR_LOAD:  state_next = ADDR_SEL;
            ADDR_SEL:   state_next = (instr.opcode == OPC_LDR) ? MEM_READ : STR_RD_B;
            MEM_READ:   state_next = MEM_SELECT;
            MEM_SELECT: state_next = WRITE_BACK;
            STR_RD_B:   state_next = STR_EXEC;
            STR_EXEC:   state_next = MEM_WRITE;
            MEM_WRITE:  state_next = WRITE_WAIT;
            WRITE_WAIT: state_next = PC_NEXT;
            default:    state_next = IDLE;
        endcase
    end

    always_comb begin
        ctrl          = '0;
        load_pc       = 1'b0;
        pc_from_start = 1'b0;
        load_ir       = 1'b0;
        load_addr     = 1'b0;
        addr_from_pc  = 1'b0;
        mem_we        = 1'b0;
        case (state)
            PC_FIRST: begin
                load_pc       = 1'b1;
                pc_from_start = 1'b1;
            end
            PC_NEXT:  load_pc = 1'b1;
            PC_READ:  addr_from_pc = 1'b1; // data comes back in IR_LOAD
            IR_LOAD:  load_ir = 1'b1;
            RD_A: begin
                ctrl.reg_sel = SEL_RN;
                ctrl.load_a  = 1'b1;
            end
            RD_B:     ctrl.load_b = 1'b1;
            EXEC: begin
                ctrl.load_c      = 1'b1;
                ctrl.load_status = 1'b1;
                ctrl.zero_a      = (instr.opcode == OPC_MOV);
                ctrl.use_imm5    = is_mem;  // Rn + imm5
            end
            WRITE_BACK: begin
                ctrl.reg_sel = SEL_RD;
                ctrl.reg_wr  = 1'b1;
                if (is_mov_imm) ctrl.wb_sel = WB_IMM8;
                else if (instr.opcode == OPC_LDR) ctrl.wb_sel = WB_MEM;
            end
            ADDR_LOAD: load_addr = 1'b1;
            MEM_SELECT: begin
                ctrl.reg_sel = SEL_RD;
                ctrl.wb_sel  = WB_MEM;
            end
            STR_RD_B: begin
                ctrl.reg_sel = SEL_RD;
                ctrl.load_b  = 1'b1;
            end
            STR_EXEC: begin
                ctrl.load_c      = 1'b1;
                ctrl.load_status = 1'b1;
                ctrl.zero_a      = 1'b1;
                ctrl.no_shift    = 1'b1; // shift bits belong to imm5 here
            end
            MEM_WRITE: mem_we = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            halted <= 1'b0;
        end else begin
            state <= state_next;
            if (state == IDLE && start) halted <= 1'b0;
            else if (state == DECODE && instr.opcode == OPC_HALT) halted <= 1'b1;
        end
    end

    assign busy = (state != IDLE);

endmodule

// ==== hw/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath (
    input  logic            clk,
    input  cpu_pkg::instr_t instr,
    input  cpu_pkg::ctrl_t  ctrl,
    input  cpu_pkg::word_t  mdata,
    output cpu_pkg::word_t  c_out,
    output cpu_pkg::flags_t flags
);
    import cpu_pkg::*;

    reg_addr_t reg_idx;
    word_t     wb_data;
    word_t     rd_data;
    word_t     a_q;
    word_t     b_q;
    word_t     a_val;
    word_t     b_val;
    word_t     alu_res;
    flags_t    alu_flags;

    // one index serves both read and write
    always_comb begin
        case (ctrl.reg_sel)
            SEL_RN:  reg_idx = instr.rn;
            SEL_RD:  reg_idx = instr.rd;
            default: reg_idx = instr.rm;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_IMM8: wb_data = instr.imm8;
            WB_MEM:  wb_data = mdata;
            default: wb_data = c_out;
        endcase
    end

    reg_file u_rf (
        .clk     (clk),
        .wr_en   (ctrl.reg_wr),
        .wr_addr (reg_idx),
        .wr_data (wb_data),
        .rd_addr (reg_idx),
        .rd_data (rd_data)
    );

    assign a_val = ctrl.zero_a ? '0 : a_q;
    assign b_val = ctrl.use_imm5 ? instr.imm5 : b_q;

    alu_shift u_alu (
        .a         (a_val),
        .b         (b_val),
        .shift     (instr.shift),
        .no_shift  (ctrl.no_shift | ctrl.use_imm5),
        .op        (instr.op),
        .result    (alu_res),
        .alu_flags (alu_flags)
    );

    always_ff @(posedge clk) begin
        if (ctrl.load_a) a_q <= rd_data;
        if (ctrl.load_b) b_q <= rd_data;
        if (ctrl.load_c) c_out <= alu_res;
        if (ctrl.load_status) flags <= alu_flags;
    end

endmodule

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  cpu_pkg::addr_t  start_pc,
    input  cpu_pkg::word_t  mem_rdata,
    output cpu_pkg::addr_t  mem_addr,
    output cpu_pkg::word_t  mem_wdata,
    output logic            mem_we,
    output cpu_pkg::word_t  out,
    output cpu_pkg::flags_t flags,
    output logic            busy,
    output logic            halted
);
    import cpu_pkg::*;

    addr_t  pc;
    word_t  ir;
    addr_t  dr;
    instr_t instr;
    ctrl_t  ctrl;
    word_t  c_val;
    logic   load_pc;
    logic   pc_from_start;
    logic   load_ir;
    logic   load_addr;
    logic   addr_from_pc;

    always_ff @(posedge clk) begin
        if (load_pc) pc <= pc_from_start ? start_pc : pc + 1'b1;
        if (load_ir) ir <= mem_rdata;
        if (load_addr) dr <= c_val[ADDR_W-1:0]; // data address from C
    end

    assign mem_addr  = addr_from_pc ? pc : dr;
    assign mem_wdata = c_val;
    assign out       = c_val;

    always_comb begin
        instr.opcode = opcode_e'(ir[15:13]);
        instr.op     = alu_op_e'(ir[12:11]);
        instr.rn     = ir[10:8];
        instr.rd     = ir[7:5];
        instr.shift  = shift_e'(ir[4:3]);
        instr.rm     = ir[2:0];
        instr.imm5   = {{(WORD_W - 5){ir[4]}}, ir[4:0]};
        instr.imm8   = {{(WORD_W - 8){ir[7]}}, ir[7:0]};
    end

    cpu_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .instr         (instr),
        .ctrl          (ctrl),
        .load_pc       (load_pc),
        .pc_from_start (pc_from_start),
        .load_ir       (load_ir),
        .load_addr     (load_addr),
        .addr_from_pc  (addr_from_pc),
        .mem_we        (mem_we),
        .busy          (busy),
        .halted        (halted)
    );

    cpu_datapath u_dp (
        .clk   (clk),
        .instr (instr),
        .ctrl  (ctrl),
        .mdata (mem_rdata),
        .c_out (c_val),
        .flags (flags)
    );

endmodule

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::addr_t    addr,
    input  cpu_pkg::word_t    wdata,
    input  logic              we,
    input  logic              busy,
    input  cpu_pkg::apb_req_t apb,
    output cpu_pkg::word_t    rdata,
    output cpu_pkg::apb_rsp_t apb_rsp
);
    import cpu_pkg::*;

    word_t mem [MEM_DEPTH];
    word_t apb_rdata;
    logic  acc_cnt;   // high in the second access cycle
    logic  refused;   // busy seen at setup
    logic  setup;
    logic  access;
    logic  apb_wr;

    assign setup  = apb.psel && !apb.penable;
    assign access = apb.psel && apb.penable;
    assign apb_wr = apb_rsp.pready && apb.pwrite && !refused;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_cnt <= 1'b0;
            refused <= 1'b0;
        end else begin
            if (setup) refused <= busy;
            acc_cnt <= access && !acc_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        else if (apb_wr) mem[apb.paddr] <= apb.pwdata;
        rdata <= mem[addr];
        if (access && !acc_cnt) apb_rdata <= mem[apb.paddr]; // wait state
    end

    always_comb begin
        apb_rsp.prdata  = apb_rdata;
        apb_rsp.pready  = access && acc_cnt;
        apb_rsp.pslverr = access && acc_cnt && refused;
    end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  cpu_pkg::addr_t    start_pc,
    input  cpu_pkg::apb_req_t apb,
    output cpu_pkg::apb_rsp_t apb_rsp,
    output cpu_pkg::word_t    out,
    output cpu_pkg::flags_t   flags,
    output logic              busy,
    output logic              halted
);
    import cpu_pkg::*;

    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_we;

    cpu_core u_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .start_pc  (start_pc),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .out       (out),
        .flags     (flags),
        .busy      (busy),
        .halted    (halted)
    );

    data_ram u_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .we      (mem_we),
        .busy    (busy),
        .apb     (apb),
        .rdata   (mem_rdata),
        .apb_rsp (apb_rsp)
    );

endmodule

// ==== sim/cpu_chk.sv ====
`timescale 1ns/1ps

module cpu_chk (
    input logic              clk,
    input logic              rst_n,
    input cpu_pkg::apb_req_t apb,
    input cpu_pkg::apb_rsp_t apb_rsp,
    input logic              we,
    input logic              busy
);
    import cpu_pkg::*;

    // one wait state, so pready only in the second access cycle
    a_pready_access: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pready |-> (apb.psel && apb.penable && $past(apb.psel && apb.penable)))
        else $error("pready outside the second access cycle");

    a_pslverr_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_rsp.pready || apb_rsp.pslverr) |->
            (apb_rsp.pready && (apb_rsp.pslverr == $past(busy, 2))))
        else $error("pslverr does not match busy at setup");

    a_we_busy: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> busy)
        else $error("core write while idle");

    // address held from setup until the transfer completes
    a_paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (apb.psel && apb.penable) |-> $stable(apb.paddr))
        else $error("paddr changed during transfer");

endmodule

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    typedef struct packed {
        logic [7:0][15:0] prog;   // prog[0] sits at pc
        addr_t            pc;
        addr_t            pre_addr0;
        word_t            pre_data0;
        addr_t            pre_addr1;
        word_t            pre_data1;
        logic             busy_wr;
        addr_t            busy_addr;
        word_t            busy_data;
        word_t            exp_c;
        flags_t           exp_f;
        addr_t            chk_addr0;
        word_t            chk_data0;
        addr_t            chk_addr1;
        word_t            chk_data1;
    } test_row_t;

    localparam int NUM_ROWS = 8;
    localparam word_t HALT_W = 16'hE000;

    logic      clk;
    logic      rst_n;
    logic      start;
    addr_t     start_pc;
    apb_req_t  apb;
    apb_rsp_t  apb_rsp;
    word_t     out;
    flags_t    flags;
    logic      busy;
    logic      halted;

    test_row_t rows [NUM_ROWS];
    string     row_name [NUM_ROWS];
    logic [31:0] rng;
    int        err_count;
    int        pass_count;
    int        fail_count;

    cpu_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .start_pc (start_pc),
        .apb      (apb),
        .apb_rsp  (apb_rsp),
        .out      (out),
        .flags    (flags),
        .busy     (busy),
        .halted   (halted)
    );

    bind data_ram cpu_chk u_chk (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb     (apb),
        .apb_rsp (apb_rsp),
        .we      (we),
        .busy    (busy)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t sext8(input logic [7:0] b);
        return {{8{b[7]}}, b};
    endfunction

    function automatic addr_t off5(input addr_t base, input logic [4:0] i);
        addr_t r;
        r = base + {{3{i[4]}}, i};
        return r;
    endfunction

    function automatic word_t shifted(input word_t v, input logic [1:0] sh);
        case (sh)
            2'd1:    return {v[14:0], 1'b0};
            2'd2:    return {1'b0, v[15:1]};
            2'd3:    return {v[15], v[15:1]};
            default: return v;
        endcase
    endfunction

    // flags from the signed difference, computed wide
    function automatic flags_t cmp_flags(input word_t a, input word_t b);
        int     sa;
        int     sb;
        int     d;
        flags_t f;
        sa = $signed(a);
        sb = $signed(b);
        d = sa - sb;
        f.z = (d[15:0] == 16'h0);
        f.n = d[15];
        f.v = (d > 32767) || (d < -32768);
        return f;
    endfunction

    // destination is imm8[7:5], the fields overlap
    function automatic word_t enc_mov_imm(input logic [7:0] imm8);
        return {3'b110, 2'b10, 3'b000, imm8};
    endfunction

    function automatic word_t enc_mov_reg(input logic [2:0] rd, input logic [2:0] rm,
                                          input logic [1:0] sh);
        return {3'b110, 2'b00, 3'b000, rd, sh, rm};
    endfunction

    function automatic word_t enc_alu(input logic [1:0] op, input logic [2:0] rd,
                                      input logic [2:0] rn, input logic [2:0] rm,
                                      input logic [1:0] sh);
        return {3'b101, op, rn, rd, sh, rm};
    endfunction

    function automatic word_t enc_mem(input logic is_str, input logic [2:0] rd,
                                      input logic [2:0] rn, input logic [4:0] imm5);
        return {(is_str ? 3'b100 : 3'b011), 2'b00, rn, rd, imm5};
    endfunction

    function automatic test_row_t blank_row(input addr_t pc);
        test_row_t r;
        r = '0;
        for (int i = 0; i < 8; i++) r.prog[i] = HALT_W;
        r.pc = pc;
        r.pre_addr0 = 8'hF8;
        r.pre_addr1 = 8'hF9;
        return r;
    endfunction

    // r2 = 0x40, r3 = mem[3e], r4 = mem[3f], then CMP r3, r4
    function automatic test_row_t cmp_row(input word_t x, input word_t y);
        test_row_t r;
        r = blank_row(8'h00);
        r.prog[0] = enc_mov_imm(8'h40);
        r.prog[1] = enc_mem(1'b0, 3'd3, 3'd2, 5'h1E);
        r.prog[2] = enc_mem(1'b0, 3'd4, 3'd2, 5'h1F);
        r.prog[3] = enc_alu(2'd1, 3'd0, 3'd3, 3'd4, 2'd0);
        r.pre_addr0 = off5(8'h40, 5'h1E);
        r.pre_data0 = x;
        r.pre_addr1 = off5(8'h40, 5'h1F);
        r.pre_data1 = y;
        r.exp_c = x - y;
        r.exp_f = cmp_flags(x, y);
        r.chk_addr0 = r.pre_addr0;
        r.chk_data0 = x;
        r.chk_addr1 = r.pre_addr1;
        r.chk_data1 = y;
        return r;
    endfunction

    task automatic build_table();
        word_t x;
        word_t y;
        word_t v;
        test_row_t r;
        // MOV imm, MOV reg LSL, MVN, stores
        r = blank_row(8'h00);
        r.prog[0] = enc_mov_imm(8'hF9);
        r.prog[1] = enc_mov_imm(8'h40);
        r.prog[2] = enc_mov_reg(3'd1, 3'd7, 2'd1);
        r.prog[3] = enc_mem(1'b1, 3'd1, 3'd2, 5'h00);
        r.prog[4] = enc_alu(2'd3, 3'd4, 3'd0, 3'd7, 2'd0);
        r.prog[5] = enc_mem(1'b1, 3'd4, 3'd2, 5'h01);
        r.chk_addr0 = 8'h40;
        r.chk_data0 = shifted(sext8(8'hF9), 2'd1);
        r.chk_addr1 = off5(8'h40, 5'h01);
        r.chk_data1 = ~sext8(8'hF9);
        r.exp_c = r.chk_data1;
        rows[0] = r;
        row_name[0] = "mov_shift_mvn";
        // ADD with LSR, AND with ASR on random operands
        rng = xorshift(rng);
        x = rng[15:0];
        rng = xorshift(rng);
        y = rng[15:0];
        r = cmp_row(x, y);
        r.prog[3] = enc_alu(2'd0, 3'd5, 3'd3, 3'd4, 2'd2);
        r.prog[4] = enc_alu(2'd2, 3'd6, 3'd3, 3'd4, 2'd3);
        r.prog[5] = enc_mem(1'b1, 3'd5, 3'd2, 5'h00);
        r.prog[6] = enc_mem(1'b1, 3'd6, 3'd2, 5'h01);
        r.chk_addr0 = 8'h40;
        r.chk_data0 = x + shifted(y, 2'd2);
        r.chk_addr1 = 8'h41;
        r.chk_data1 = x & shifted(y, 2'd3);
        r.exp_c = r.chk_data1;
        r.exp_f = '0;
        rows[1] = r;
        row_name[1] = "add_and_random";
        rows[2] = cmp_row(x, x);
        row_name[2] = "cmp_equal";
        rows[3] = cmp_row(16'h0005, 16'h0009);
        row_name[3] = "cmp_negative";
        rows[4] = cmp_row(16'h8000, 16'h0001);
        row_name[4] = "cmp_overflow";
        r = cmp_row(16'h1234, 16'h1234);
        r.prog[4] = enc_alu(2'd0, 3'd5, 3'd3, 3'd4, 2'd0);
        r.exp_c = 16'h1234 + 16'h1234;
        r.exp_f = '0;
        rows[5] = r;
        row_name[5] = "cmp_then_add";
        // value moves 3c -> 1d -> 3f through r3 and r5
        rng = xorshift(rng);
        v = rng[15:0];
        r = blank_row(8'h00);
        r.prog[0] = enc_mov_imm(8'h40);
        r.prog[1] = enc_mem(1'b0, 3'd3, 3'd2, 5'h1C);
        r.prog[2] = enc_mov_imm(8'h20);
        r.prog[3] = enc_mem(1'b1, 3'd3, 3'd1, 5'h1D);
        r.prog[4] = enc_mem(1'b0, 3'd5, 3'd1, 5'h1D);
        r.prog[5] = enc_mem(1'b1, 3'd5, 3'd2, 5'h1F);
        r.pre_addr0 = off5(8'h40, 5'h1C);
        r.pre_data0 = v;
        r.pre_addr1 = off5(8'h20, 5'h1D);
        r.pre_data1 = 16'h0000;
        r.chk_addr0 = off5(8'h20, 5'h1D);
        r.chk_data0 = v;
        r.chk_addr1 = off5(8'h40, 5'h1F);
        r.chk_data1 = v;
        r.exp_c = v;
        rows[6] = r;
        row_name[6] = "ldr_str_neg_offset";
        // runs from 0x80, a HALT at 0 catches a wrong start
        r = blank_row(8'h80);
        r.prog[0] = enc_mov_imm(8'h40);
        r.prog[1] = enc_mov_imm(8'hF9);
        r.prog[2] = enc_mem(1'b1, 3'd7, 3'd2, 5'h02);
        r.prog[3] = enc_alu(2'd3, 3'd4, 3'd0, 3'd7, 2'd0);
        r.pre_addr0 = 8'h00;
        r.pre_data0 = HALT_W;
        r.pre_addr1 = 8'h50;
        r.pre_data1 = 16'h1234;
        r.busy_wr = 1'b1;
        r.busy_addr = 8'h50;
        r.busy_data = 16'hDEAD;
        r.chk_addr0 = 8'h42;
        r.chk_data0 = sext8(8'hF9);
        r.chk_addr1 = 8'h50;
        r.chk_data1 = 16'h1234;
        r.exp_c = ~sext8(8'hF9);
        rows[7] = r;
        row_name[7] = "start_pc_busy_apb";
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail t=%0t %s: got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    // setup, access, hold through the completing edge
    task automatic apb_transfer(input logic wr, input addr_t a, input word_t d,
                                output word_t rdata, output logic err);
        int n;
        apb.psel = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite = wr;
        apb.paddr = a;
        apb.pwdata = d;
        @(negedge clk);
        apb.penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!apb_rsp.pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!apb_rsp.pready) begin
            $display("APB transfer to address %h timed out without pready", a);
            err_count++;
        end
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(negedge clk);
        apb = '0;
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        while (!halted && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            $display("core did not reach HALT within 2000 cycles");
            err_count++;
        end
    endtask

    task automatic run_row(input int idx);
        test_row_t r;
        word_t     rd;
        logic      err;
        int        errs_before;
        r = rows[idx];
        errs_before = err_count;
        apb_transfer(1'b1, r.pre_addr0, r.pre_data0, rd, err);
        apb_transfer(1'b1, r.pre_addr1, r.pre_data1, rd, err);
        for (int i = 0; i < 8; i++) begin
            apb_transfer(1'b1, r.pc + i[7:0], r.prog[i], rd, err);
        end
        start_pc = r.pc;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (r.busy_wr) begin
            apb_transfer(1'b1, r.busy_addr, r.busy_data, rd, err);
            if (err !== 1'b1) begin
                $display("APB write while the core ran was not refused with pslverr");
                err_count++;
            end
        end
        wait_halted();
        check_word("out", out, r.exp_c);
        if (flags !== r.exp_f) begin
            $display("Fail t=%0t flags: got %b expected %b", $time, flags, r.exp_f);
            err_count++;
        end
        apb_transfer(1'b0, r.chk_addr0, 16'h0000, rd, err);
        check_word($sformatf("mem[%h]", r.chk_addr0), rd, r.chk_data0);
        apb_transfer(1'b0, r.chk_addr1, 16'h0000, rd, err);
        check_word($sformatf("mem[%h]", r.chk_addr1), rd, r.chk_data1);
        if (err_count == errs_before) begin
            $display("test %0d %s passed", idx + 1, row_name[idx]);
            pass_count++;
        end else begin
            $display("test %0d %s failed", idx + 1, row_name[idx]);
            fail_count++;
        end
    endtask

    initial begin
        word_t rd;
        logic  err;
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        start_pc = '0;
        apb = '0;
        err_count = 0;
        pass_count = 0;
        fail_count = 0;
        rng = 32'h46c1a924;
        build_table();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // idle after reset, APB round trip
        if (busy !== 1'b0 || halted !== 1'b0) begin
            $display("busy or halted not low after reset");
            err_count++;
        end
        apb_transfer(1'b1, 8'hF0, 16'hA55A, rd, err);
        if (err !== 1'b0) begin
            $display("APB write while idle returned pslverr");
            err_count++;
        end
        apb_transfer(1'b0, 8'hF0, 16'h0000, rd, err);
        check_word("prdata", rd, 16'hA55A);
        if (err !== 1'b0) begin
            $display("APB read while idle returned pslverr");
            err_count++;
        end
        if (err_count == 0) begin
            $display("test 0 reset_apb passed");
            pass_count++;
        end else begin
            $display("test 0 reset_apb failed");
            fail_count++;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 pass_count + fail_count, pass_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hw/cpu_pkg.sv
hw/reg_file.sv
hw/alu_shift.sv
hw/cpu_ctrl.sv
hw/cpu_datapath.sv
hw/cpu_core.sv
hw/data_ram.sv
hw/cpu_top.sv
sim/cpu_chk.sv
sim/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only --timing
TOP       = cpu_tb
FILELIST  = sources.f
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
